//--- source/sifhPkg.sv
package sifhPkg;

    // ****************************************
    // sizes
    // ****************************************

    // sample and bin widths
    localparam int NP = 10;
    localparam int NB = 6;
    localparam int NUM_BINS = 2 ** NB;
    // top bin is reserved as the drop address
    localparam int INVALID_BIN = NUM_BINS - 1;

    // fine window, offsets 0 .. FINE_BINS-1
    localparam int FINE_BINS = 63;
    localparam int MAX_START = 2 ** NP - FINE_BINS;
    localparam int HALF_SPAN = 2 ** (NB - 1);

    // frame shape, sample loop innermost
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM = 4;
    localparam int ACQ_NUM = 3;
    localparam int PASS_LEN = PIXEL_NUM * DATA_NUM * ACQ_NUM;

    // counter and index widths
    localparam int CNT_W = 8;
    localparam int PIX_W = 2;
    // stages after acceptance: tag, bin request, bin update
    localparam int PIPE_DEPTH = 3;

    // ****************************************
    // types
    // ****************************************

    // coarse view of a sample
    typedef struct packed {
        logic [NB-1:0]    coarse;
        logic [NP-NB-1:0] rest;
    } sampleSplit;

    // same word, raw number or coarse split
    typedef union packed {
        logic [NP-1:0] raw;
        sampleSplit    split;
    } sampleWord;

    // filter to histogram
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] pixel;
        logic [NB-1:0]    bin;
    } binReq;

    // histogram to peak tracker
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] pixel;
        logic [NB-1:0]    bin;
        logic [CNT_W-1:0] count;
    } binUpdate;

    // accepted sample with its pixel index
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] pixel;
        sampleWord        sample;
    } sampleTag;

    // one word per pixel
    typedef logic [PIXEL_NUM-1:0][NP-1:0] peakVector;
    typedef logic [PIXEL_NUM-1:0][NB-1:0] binVector;

endpackage

//--- source/sifhControl.sv
`timescale 1ns/1ps

module sifhControl (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  sifhPkg::sampleWord data,
    output logic               busy,
    output sifhPkg::sampleTag  tag,
    output logic               fine,
    output logic               clearHist,
    output logic               coarseEnd,
    output logic               fineEnd
);

    // frame position counters
    logic [$clog2(sifhPkg::DATA_NUM)-1:0] sampleCnt;
    logic [sifhPkg::PIX_W-1:0]            pixelCnt;
    logic [$clog2(sifhPkg::ACQ_NUM)-1:0]  acqCnt;
    // drain step, zero when idle
    logic [2:0] drainCnt;

    logic accept;
    logic dataLast;
    logic pixelLast;
    logic passLast;

    // only back-pressure is busy
    assign accept = wrEn && !busy;

    assign dataLast  = (int'(sampleCnt) == sifhPkg::DATA_NUM - 1);
    assign pixelLast = (int'(pixelCnt) == sifhPkg::PIXEL_NUM - 1);
    assign passLast  = dataLast && pixelLast && (int'(acqCnt) == sifhPkg::ACQ_NUM - 1);

    // ****************************************
    // sample, pixel and acquisition loops
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            tag       <= '0;
        end else begin
            // tag carries the pixel the sample belongs to
            tag <= '{valid: accept, pixel: pixelCnt, sample: data};
            if (accept) begin
                if (dataLast) begin
                    sampleCnt <= '0;
                    if (pixelLast) begin
                        pixelCnt <= '0;
                        // wraps to zero at pass end
                        acqCnt <= (int'(acqCnt) == sifhPkg::ACQ_NUM - 1) ? '0 : acqCnt + 1'b1;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // ****************************************
    // drain schedule between passes
    // ****************************************
    // step PIPE_DEPTH   -> end pulse, peaks final
    // step PIPE_DEPTH+1 -> clear pulse
    // step PIPE_DEPTH+2 -> toggle pass, release busy
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy      <= 1'b0;
            fine      <= 1'b0;
            drainCnt  <= '0;
            clearHist <= 1'b0;
            coarseEnd <= 1'b0;
            fineEnd   <= 1'b0;
        end else begin
            // pulses default low
            clearHist <= 1'b0;
            coarseEnd <= 1'b0;
            fineEnd   <= 1'b0;
            if (accept && passLast) begin
                busy     <= 1'b1;
                drainCnt <= 3'd1;
            end else if (drainCnt != '0) begin
                if (int'(drainCnt) == sifhPkg::PIPE_DEPTH) begin
                    coarseEnd <= !fine;
                    fineEnd   <= fine;
                end
                if (int'(drainCnt) == sifhPkg::PIPE_DEPTH + 1) begin
                    clearHist <= 1'b1;
                end
                if (int'(drainCnt) == sifhPkg::PIPE_DEPTH + 2) begin
                    drainCnt <= '0;
                    busy     <= 1'b0;
                    fine     <= !fine;
                end else begin
                    drainCnt <= drainCnt + 1'b1;
                end
            end
        end
    end

    // busy only while draining, loops parked at pass start so nothing was counted
    assert property (@(posedge clk) disable iff (!combin_res)
        busy |-> (drainCnt != '0) && (sampleCnt == '0) && (pixelCnt == '0) && (acqCnt == '0));

endmodule

//--- source/dataFilter.sv
`timescale 1ns/1ps

module dataFilter (
    input  logic               clk,
    input  logic               combin_res,
    input  sifhPkg::sampleTag  tag,
    input  logic               fine,
    input  sifhPkg::peakVector windowStart,
    output sifhPkg::binReq     req
);

    // window start of the tagged pixel
    logic [sifhPkg::NP-1:0] start;
    // distance from window start
    logic [sifhPkg::NP-1:0] offset;
    logic [sifhPkg::NB-1:0] bin;
    logic                   keep;

    // ****************************************
    // bin selection per pass
    // ****************************************
    always_comb begin
        start  = windowStart[tag.pixel];
        offset = tag.sample.raw - start;
        if (fine) begin
            // inside start .. start+FINE_BINS-1 only
            keep = (tag.sample.raw >= start) && (int'(offset) < sifhPkg::FINE_BINS);
            // offset below FINE_BINS never hits the drop bin
            bin = offset[sifhPkg::NB-1:0];
        end else begin
            // top NB bits of the sample
            bin  = tag.sample.split.coarse;
            keep = (int'(bin) != sifhPkg::INVALID_BIN);
        end
    end

    // one register stage
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            req <= '0;
        end else begin
            // dropped samples just lose valid
            req <= '{valid: tag.valid && keep, pixel: tag.pixel, bin: bin};
        end
    end

endmodule

//--- source/histBuilder.sv
`timescale 1ns/1ps

module histBuilder (
    input  logic              clk,
    input  logic              combin_res,
    input  sifhPkg::binReq    req,
    input  logic              clearHist,
    output sifhPkg::binUpdate upd
);

    // ****************************************
    // bin storage
    // ****************************************
    // one histogram per pixel, pixel index on top of the address
    logic [sifhPkg::CNT_W-1:0] binMem [sifhPkg::PIXEL_NUM*sifhPkg::NUM_BINS];
    // set once a bin has been written in this pass
    logic [sifhPkg::PIXEL_NUM*sifhPkg::NUM_BINS-1:0] binUsed;

    logic [sifhPkg::PIX_W+sifhPkg::NB-1:0] addr;
    logic [sifhPkg::CNT_W-1:0]             oldCount;
    logic [sifhPkg::CNT_W-1:0]             newCount;

    assign addr = {req.pixel, req.bin};

    // stale entries read as zero
    assign oldCount = binUsed[addr] ? binMem[addr] : '0;
    assign newCount = oldCount + 1'b1;

    // write lands before the next read, so back-to-back hits chain
    always_ff @(posedge clk) begin
        if (req.valid) begin
            binMem[addr] <= newCount;
        end
    end

    // bitmap clear in one cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binUsed <= '0;
        end else if (clearHist) begin
            binUsed <= '0;
        end else if (req.valid) begin
            binUsed[addr] <= 1'b1;
        end
    end

    // ****************************************
    // update to peak tracker
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            upd <= '0;
        end else begin
            upd <= '{
                valid: req.valid,
                pixel: req.pixel,
                bin:   req.bin,
                count: newCount
            };
        end
    end

    // filter must never forward the reserved drop bin
    assert property (@(posedge clk) disable iff (!combin_res)
        req.valid |-> (int'(req.bin) != sifhPkg::INVALID_BIN));

endmodule

//--- source/peakDetector.sv
`timescale 1ns/1ps

module peakDetector (
    input  logic              clk,
    input  logic              combin_res,
    input  sifhPkg::binUpdate upd,
    input  logic              clearHist,
    output sifhPkg::binVector peakBins
);

    // ****************************************
    // running maximum per pixel
    // ****************************************
    // highest count seen so far in this pass
    logic [sifhPkg::PIXEL_NUM-1:0][sifhPkg::CNT_W-1:0] maxCount;

    // count of the pixel being updated
    logic [sifhPkg::CNT_W-1:0] curMax;
    logic                      newLead;

    assign curMax = maxCount[upd.pixel];

    // strictly greater, first bin to reach a count keeps the lead
    assign newLead = upd.valid && (upd.count > curMax);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '0;
            peakBins <= '0;
        end else if (clearHist) begin
            // fresh start for the next pass
            maxCount <= '0;
            peakBins <= '0;
        end else if (newLead) begin
            maxCount[upd.pixel] <= upd.count;
            peakBins[upd.pixel] <= upd.bin;
        end
    end

endmodule

//--- source/windowCalc.sv
`timescale 1ns/1ps

module windowCalc (
    input  logic               clk,
    input  logic               combin_res,
    input  sifhPkg::binVector  peakBins,
    input  logic               coarseEnd,
    input  logic               fineEnd,
    output sifhPkg::peakVector windowStart,
    output sifhPkg::peakVector result,
    output logic               resultValid
);

    // coarse peak back in sample units
    sifhPkg::peakVector center;
    sifhPkg::peakVector startNext;
    sifhPkg::peakVector resultNext;

    // ****************************************
    // window placement and final value
    // ****************************************
    always_comb begin
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            center[p] = {peakBins[p], {(sifhPkg::NP - sifhPkg::NB){1'b0}}};
            // clamp low edge
            if (int'(center[p]) <= sifhPkg::HALF_SPAN) begin
                startNext[p] = '0;
            // clamp high edge, window must end at full scale
            end else if (int'(center[p]) - sifhPkg::HALF_SPAN > sifhPkg::MAX_START) begin
                startNext[p] = sifhPkg::NP'(sifhPkg::MAX_START);
            end else begin
                startNext[p] = center[p] - sifhPkg::NP'(sifhPkg::HALF_SPAN);
            end
            // fine peak bin is an offset into the window
            resultNext[p] = windowStart[p] + {{(sifhPkg::NP - sifhPkg::NB){1'b0}}, peakBins[p]};
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windowStart <= '0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            if (coarseEnd) begin
                windowStart <= startNext;
            end
            if (fineEnd) begin
                result <= resultNext;
            end
            // single cycle strobe
            resultValid <= fineEnd;
        end
    end

    // filter relies on a window that never runs past full scale
    for (genvar p = 0; p < sifhPkg::PIXEL_NUM; p++) begin : gStartCheck
        assert property (@(posedge clk) disable iff (!combin_res)
            int'(windowStart[p]) <= sifhPkg::MAX_START);
    end

endmodule

//--- source/sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   wrEn,
    input  logic [sifhPkg::NP-1:0] data,
    output logic                   busy,
    output sifhPkg::peakVector     result,
    output logic                   resultValid
);

    // ****************************************
    // pipeline wiring
    // ****************************************
    sifhPkg::sampleWord dataWord;
    sifhPkg::sampleTag  tag;
    sifhPkg::binReq     req;
    sifhPkg::binUpdate  upd;
    sifhPkg::binVector  peakBins;
    sifhPkg::peakVector windowStart;

    // pass and drain controls
    logic fine;
    logic clearHist;
    logic coarseEnd;
    logic fineEnd;

    assign dataWord.raw = data;

    // counters and drain timing
    sifhControl uControl (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (dataWord),
        .busy       (busy),
        .tag        (tag),
        .fine       (fine),
        .clearHist  (clearHist),
        .coarseEnd  (coarseEnd),
        .fineEnd    (fineEnd)
    );

    // sample to bin address
    dataFilter uFilter (
        .clk         (clk),
        .combin_res  (combin_res),
        .tag         (tag),
        .fine        (fine),
        .windowStart (windowStart),
        .req         (req)
    );

    // counting
    histBuilder uHist (
        .clk        (clk),
        .combin_res (combin_res),
        .req        (req),
        .clearHist  (clearHist),
        .upd        (upd)
    );

    // most frequent bin per pixel
    peakDetector uPeak (
        .clk        (clk),
        .combin_res (combin_res),
        .upd        (upd),
        .clearHist  (clearHist),
        .peakBins   (peakBins)
    );

    // window starts and results
    windowCalc uWindow (
        .clk         (clk),
        .combin_res  (combin_res),
        .peakBins    (peakBins),
        .coarseEnd   (coarseEnd),
        .fineEnd     (fineEnd),
        .windowStart (windowStart),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

//--- verif/sifhModel.svh
`ifndef SIFH_MODEL_SVH
`define SIFH_MODEL_SVH

// ****************************************
// reference model
// ****************************************

// most frequent bin of one pixel in one pass
function automatic int findPeak(input bit finePass, input int pix, input int start);
    int counts [sifhPkg::NUM_BINS];
    int best;
    int bestBin;
    int value;
    int bin;
    bit keep;
    best    = 0;
    bestBin = 0;
    for (int b = 0; b < sifhPkg::NUM_BINS; b++) begin
        counts[b] = 0;
    end
    for (int i = 0; i < sifhPkg::PASS_LEN; i++) begin
        // sample loop innermost, then pixel
        if ((i / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM == pix) begin
            if (finePass) begin
                value = fineSamples[i];
                bin   = value - start;
                // outside the window is thrown away
                keep  = (value >= start) && (bin < sifhPkg::FINE_BINS);
            end else begin
                value = coarseSamples[i];
                bin   = value / (2 ** (sifhPkg::NP - sifhPkg::NB));
                // top bin is the drop address
                keep  = (bin != sifhPkg::INVALID_BIN);
            end
            if (keep) begin
                counts[bin]++;
                // strictly greater, first to reach a count keeps it
                if (counts[bin] > best) begin
                    best    = counts[bin];
                    bestBin = bin;
                end
            end
        end
    end
    return bestBin;
endfunction

// window start around a coarse bin, clamped to the data range
function automatic int windowFor(input int coarseBin);
    int center;
    center = coarseBin * (2 ** (sifhPkg::NP - sifhPkg::NB));
    if (center <= sifhPkg::HALF_SPAN) begin
        return 0;
    end
    if (center - sifhPkg::HALF_SPAN > sifhPkg::MAX_START) begin
        return sifhPkg::MAX_START;
    end
    return center - sifhPkg::HALF_SPAN;
endfunction

// expected final word for one pixel of the stored frame
function automatic int expectedResult(input int pix);
    int start;
    start = windowFor(findPeak(1'b0, pix, 0));
    return start + findPeak(1'b1, pix, start);
endfunction

`endif

//--- verif/sifhTb.sv
`timescale 1ns/1ps

module sifhTb;

    // ****************************************
    // run constants
    // ****************************************
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int FRAMES       = 8;
    localparam int TOP_VALUE    = 2 ** sifhPkg::NP - 1;
    // two passes per frame, each with gaps and the drain
    localparam int LIMIT_CYCLES =
        RESET_CYCLES + FRAMES * 2 * (sifhPkg::PASS_LEN * 4 + 6);

    logic                   clk;
    logic                   combin_res;
    logic                   wrEn;
    logic [sifhPkg::NP-1:0] data;
    logic                   busy;
    sifhPkg::peakVector     result;
    logic                   resultValid;

    // accepted samples of the current frame
    int coarseSamples [sifhPkg::PASS_LEN];
    int fineSamples   [sifhPkg::PASS_LEN];

    // frame shape
    int truth  [sifhPkg::PIXEL_NUM];
    int spread [sifhPkg::PIXEL_NUM];
    int outlierPct;
    int busyOfferPct;

    `include "sifhModel.svh"

    sifhTop u_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .busy        (busy),
        .result      (result),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: frames did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

    // ****************************************
    // helpers
    // ****************************************
    task automatic expectEqual(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic int randRange(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // one sample around the pixel's true value
    function automatic int makeSample(input int pix);
        int value;
        if (randRange(0, 99) < outlierPct) begin
            value = randRange(0, TOP_VALUE);
        end else begin
            value = truth[pix] + randRange(-spread[pix], spread[pix]);
        end
        if (value < 0) begin
            value = 0;
        end
        if (value > TOP_VALUE) begin
            value = TOP_VALUE;
        end
        return value;
    endfunction

    task automatic pickFrame(input int frameIdx);
        outlierPct   = (frameIdx == 3) ? 35 : 10;
        // frame 4 hammers wrEn through every drain
        busyOfferPct = (frameIdx == 4) ? 100 : 50;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            spread[p] = randRange(0, 6);
            truth[p]  = randRange(0, TOP_VALUE);
            if (frameIdx == 2) begin
                // both ends of the range, window clamps
                truth[p] = (p % 2 == 0) ? randRange(0, 24) : randRange(TOP_VALUE - 23, TOP_VALUE);
            end else if (frameIdx == 3 && p < 2) begin
                // mostly inside the dropped coarse bin
                truth[p] = randRange(1008, TOP_VALUE);
            end
        end
    endtask

    // feed one pass of PASS_LEN accepted samples
    task automatic runPass(input bit finePass);
        int taken;
        int value;
        taken = 0;
        while (taken < sifhPkg::PASS_LEN) begin
            @(negedge clk);
            if (busy) begin
                // ignored by the DUT, never stored
                wrEn = (randRange(0, 99) < busyOfferPct);
                data = sifhPkg::NP'(randRange(0, TOP_VALUE));
            end else if (randRange(0, 3) == 0) begin
                wrEn = 1'b0;
                data = sifhPkg::NP'(randRange(0, TOP_VALUE));
            end else begin
                value = makeSample((taken / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM);
                if (finePass) begin
                    fineSamples[taken] = value;
                end else begin
                    coarseSamples[taken] = value;
                end
                wrEn  = 1'b1;
                data  = sifhPkg::NP'(value);
                taken = taken + 1;
            end
        end
        // busy rises on the edge that takes the last sample
        @(negedge clk);
        expectEqual(finePass ? "fineEndBusy" : "coarseEndBusy", 1, int'(busy));
        wrEn = busy && (randRange(0, 99) < busyOfferPct);
        data = sifhPkg::NP'(randRange(0, TOP_VALUE));
    endtask

    task automatic waitResult(input int frameIdx);
        do begin
            @(negedge clk);
            wrEn = busy && (randRange(0, 99) < busyOfferPct);
            data = sifhPkg::NP'(randRange(0, TOP_VALUE));
        end while (!resultValid);
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            expectEqual($sformatf("frame%0d pixel%0d", frameIdx, p),
                expectedResult(p), int'(result[p]));
        end
        // strobe lasts one cycle, input opens right after
        @(negedge clk);
        wrEn = 1'b0;
        expectEqual("resultPulse", 0, int'(resultValid));
        expectEqual("busyRelease", 0, int'(busy));
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        void'($urandom(32'hb718cd8b));
        combin_res   = 1'b0;
        wrEn         = 1'b0;
        data         = '0;
        outlierPct   = 0;
        busyOfferPct = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        // idle outputs out of reset
        expectEqual("resetBusy", 0, int'(busy));
        expectEqual("resetValid", 0, int'(resultValid));
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            expectEqual($sformatf("resetResult%0d", p), 0, int'(result[p]));
        end
        for (int f = 0; f < FRAMES; f++) begin
            pickFrame(f);
            runPass(1'b0);
            runPass(1'b1);
            waitResult(f);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- sifhPeak.f
+incdir+verif
source/sifhPkg.sv
source/sifhControl.sv
source/dataFilter.sv
source/histBuilder.sv
source/peakDetector.sv
source/windowCalc.sv
source/sifhTop.sv
verif/sifhTb.sv

//--- build.sh
#!/bin/sh
# build and run the sifhPeak testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module sifhTb \
    -f sifhPeak.f \
    -o sifhSim

# the log carries the verdict
./obj_dir/sifhSim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation clean"
